//--- verilog.f
corr_cfg_pkg.sv
corr_frame_pkg.sv
corr_cfg_if.sv
uart_rx.sv
uart_tx.sv
cmd_regs.sv
corr_engine.sv
frame_sender.sv
correlator_top.sv
correlator_chk.sv
tb_correlator.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP        = tb_correlator
FILELIST   = verilog.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "TEST FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_correlator.sv
/*
 * Testbench for correlator_top at 8 clocks per UART bit.
 * Commands are bit-banged on rx, frames are decoded from tx at mid-bit.
 * Expected counts come from a model fed with the same random samples.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_correlator;

	localparam int BAUD = 8;
	// about 26000 cycles for seven frames plus windows and commands
	localparam int MAX_CYCLES = 40000;

	logic       intclk;
	logic       rst_n;
	logic       rx;
	logic [3:0] line_in;
	logic       sample;
	wire        tx;
	wire        busy;

	integer seed;
	int     cycles = 0;
	int     n;

	// reference model state
	logic [3:0]  m_invert;
	logic [3:0]  m_enable;
	int          m_len;
	int          m_samples;
	logic [3:0]  m_hist [2];
	logic [15:0] m_ones [4];
	logic [15:0] m_auto [4][2];
	logic [15:0] m_cross [6];

	logic [7:0] exp_bytes [$];
	string      exp_names [$];

	correlator_top #(.BAUD_CYCLES(BAUD)) dut (
		.intclk, .rst_n, .rx, .line_in, .sample, .tx, .busy
	);

	initial intclk = 1'b0;
	always #10 intclk = ~intclk;

	always @(posedge intclk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("the run timed out after %0d cycles", cycles);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic stop_on_error();
		$display("TEST FAIL");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic step();
		@(posedge intclk);
		#1;
	endtask

	task automatic wait_cycles(input int count);
		repeat (count) step();
	endtask

	// --------------------
	// uart side
	// --------------------
	task automatic uart_send(input logic [7:0] data, input logic stop_bit);
		logic [9:0] bits;
		bits = {stop_bit, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rx = bits[i];
			wait_cycles(BAUD);
		end
		rx = 1'b1;
		wait_cycles(2 * BAUD);
	endtask

	task automatic uart_recv(output logic [7:0] data);
		while (tx !== 1'b0)
			step();
		wait_cycles(BAUD / 2);
		assert (tx === 1'b0) else begin
			$display("start bit on tx did not last to its middle at %0t", $time);
			stop_on_error();
		end
		for (int i = 0; i < 8; i++) begin
			wait_cycles(BAUD);
			data[i] = tx;
		end
		wait_cycles(BAUD);
		assert (tx === 1'b1) else begin
			$display("stop bit on tx was low at %0t", $time);
			stop_on_error();
		end
	endtask

	task automatic set_invert(input logic [3:0] mask);
		uart_send({2'd0, 2'b00, mask}, 1'b1);
		m_invert = mask;
	endtask

	task automatic set_enable(input logic [3:0] mask);
		uart_send({2'd1, 2'b00, mask}, 1'b1);
		m_enable = mask;
	endtask

	task automatic set_length(input logic [5:0] len);
		uart_send({2'd2, len}, 1'b1);
		m_len = (len == 6'd0) ? 64 : int'(len);
	endtask

	// --------------------
	// reference model
	// --------------------
	function automatic logic [15:0] sat_inc(input logic [15:0] v, input logic hit);
		return (hit && v != 16'hFFFF) ? v + 16'd1 : v;
	endfunction

	task automatic model_clear();
		m_samples = 0;
		m_hist[0] = '0;
		m_hist[1] = '0;
		for (int c = 0; c < 4; c++) begin
			m_ones[c]    = '0;
			m_auto[c][0] = '0;
			m_auto[c][1] = '0;
		end
		for (int p = 0; p < 6; p++)
			m_cross[p] = '0;
	endtask

	task automatic model_sample(input logic [3:0] line);
		logic [3:0] b;
		int         p;
		b = line ^ m_invert;
		p = 0;
		for (int c = 0; c < 4; c++) begin
			m_ones[c] = sat_inc(m_ones[c], m_enable[c] && b[c]);
			for (int l = 0; l < 2; l++)
				m_auto[c][l] = sat_inc(m_auto[c][l], m_enable[c] && b[c] == m_hist[l][c]);
		end
		for (int a = 0; a < 4; a++) begin
			for (int j = a + 1; j < 4; j++) begin
				m_cross[p] = sat_inc(m_cross[p], m_enable[a] && m_enable[j] && b[a] == b[j]);
				p++;
			end
		end
		m_hist[1] = m_hist[0];
		m_hist[0] = b;
		m_samples++;
	endtask

	task automatic expect_byte(input logic [7:0] v, input string name);
		exp_bytes.push_back(v);
		exp_names.push_back(name);
	endtask

	task automatic expect_word(input logic [15:0] v, input string name);
		expect_byte(v[15:8], {name, ".hi"});
		expect_byte(v[7:0], {name, ".lo"});
	endtask

	task automatic build_expected();
		exp_bytes.delete();
		exp_names.delete();
		expect_byte(8'hC5, "sync");
		expect_byte({4'd3, 4'd2}, "layout");
		for (int c = 0; c < 4; c++)
			expect_word(m_ones[c], $sformatf("ones[%0d]", c));
		for (int c = 0; c < 4; c++)
			for (int l = 0; l < 2; l++)
				expect_word(m_auto[c][l], $sformatf("auto[%0d] lag %0d", c, l + 1));
		n = 0;
		for (int a = 0; a < 4; a++) begin
			for (int j = a + 1; j < 4; j++) begin
				expect_word(m_cross[n], $sformatf("cross(%0d,%0d)", a, j));
				n++;
			end
		end
		expect_word(16'(m_samples), "sample_count");
	endtask

	// --------------------
	// window and frame
	// --------------------
	task automatic run_window();
		logic [31:0] r;
		while (busy !== 1'b0)
			step();
		model_clear();
		uart_send({2'd3, 6'd0}, 1'b1);
		while (busy !== 1'b1)
			step();
		while (m_samples < m_len) begin
			r       = $random(seed);
			line_in = r[4:1];
			sample  = r[0];
			if (r[0])
				model_sample(r[4:1]);
			step();
		end
		sample = 1'b0;
	endtask

	task automatic check_frame();
		logic [7:0] got;
		build_expected();
		foreach (exp_bytes[i]) begin
			uart_recv(got);
			assert (got === exp_bytes[i]) else begin
				$display("FAILED %0t %s expected %02h got %02h",
					$time, exp_names[i], exp_bytes[i], got);
				stop_on_error();
			end
		end
	endtask

	initial begin
		seed     = 32'h5846_ed98;
		rst_n    = 1'b0;
		rx       = 1'b1;
		line_in  = '0;
		sample   = 1'b0;
		m_invert = '0;
		m_enable = '1;
		m_len    = 64;
		wait_cycles(10);
		rst_n = 1'b1;
		wait_cycles(4);

		// reset configuration
		run_window();
		check_frame();

		set_invert(4'b0101);
		run_window();
		check_frame();

		// channel 2 off
		set_invert(4'b0000);
		set_enable(4'b1011);
		run_window();
		check_frame();

		set_enable(4'b1111);
		set_length(6'd5);
		run_window();
		check_frame();
		set_length(6'd0);
		run_window();
		check_frame();

		// extra START in the middle of the frame
		run_window();
		fork
			check_frame();
			begin
				wait_cycles(20 * BAUD);
				assert (busy === 1'b1) else begin
					$display("FAILED %0t busy expected 1 got %b", $time, busy);
					stop_on_error();
				end
				uart_send({2'd3, 6'd0}, 1'b1);
			end
		join
		assert (busy === 1'b1) else begin
			$display("FAILED %0t busy expected 1 got %b", $time, busy);
			stop_on_error();
		end
		n = 0;
		while (busy !== 1'b0 && n <= BAUD) begin
			step();
			n++;
		end
		assert (busy === 1'b0) else begin
			$display("busy stayed high more than %0d cycles past the last stop bit", BAUD);
			stop_on_error();
		end
		repeat (40 * BAUD) begin
			step();
			assert (busy === 1'b0 && tx === 1'b1) else begin
				$display("activity after the frame, the START sent while busy was taken");
				stop_on_error();
			end
		end

		// enable mask 0 with a low stop bit is dropped by the receiver
		uart_send({2'd1, 2'b00, 4'b0000}, 1'b0);
		run_window();
		check_frame();

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- correlator_chk.sv
/*
 * Protocol checks for correlator_top, attached with bind.
 * start is picked up from the configuration interface inside the top.
 */
`timescale 1ns/10ps
`default_nettype none

module correlator_chk (
	input wire intclk,
	input wire rst_n,
	input wire tx,
	input wire busy,
	input wire done,
	input wire integrating,
	input wire tx_load,
	input wire tx_busy,
	input wire start
);

	// line idles high when nothing is in flight
	a_tx_idle: assert property (@(posedge intclk) disable iff (!rst_n) !busy |-> tx)
		else $error("tx low while busy is low");

	a_done_window: assert property (@(posedge intclk) disable iff (!rst_n)
		done |-> !integrating)
		else $error("done pulsed inside an integration window");

	a_load_free: assert property (@(posedge intclk) disable iff (!rst_n)
		tx_load |-> !tx_busy)
		else $error("tx_load while the transmitter was busy");

	a_start_idle: assert property (@(posedge intclk) disable iff (!rst_n)
		start |-> !busy)
		else $error("start pulsed while busy");

endmodule

bind correlator_top correlator_chk u_chk (
	.intclk(intclk), .rst_n(rst_n), .tx(tx), .busy(busy), .done(done),
	.integrating(integrating), .tx_load(tx_load), .tx_busy(tx_busy),
	.start(u_cfg.start)
);

`default_nettype wire

//--- correlator_top.sv
/*
 * Correlator top level: UART command in, frame of counts out.
 * busy covers the window and the frame transmission. START is ignored while it is high.
 */
`timescale 1ns/10ps
`default_nettype none

module correlator_top
	import corr_frame_pkg::*;
#(
	parameter int BAUD_CYCLES = 8
) (
	input  wire       intclk,
	input  wire       rst_n,
	input  wire       rx,
	input  wire [3:0] line_in,
	input  wire       sample,
	output logic      tx,
	output logic      busy
);

	logic [7:0]         rx_byte;
	logic               rx_valid;
	logic [FRAME_W-1:0] counts;
	logic [SCNT_W-1:0]  sample_count;
	logic               done;
	logic               integrating;
	logic               sending;
	logic [7:0]         tx_byte;
	logic               tx_load;
	logic               tx_busy;

	corr_cfg_if u_cfg ();

	uart_rx #(.BAUD_CYCLES(BAUD_CYCLES)) u_rx (
		.intclk, .rst_n, .rx, .rx_byte, .rx_valid
	);

	cmd_regs u_regs (
		.intclk, .rst_n, .rx_byte, .rx_valid, .busy, .cfg(u_cfg.regs)
	);

	corr_engine u_engine (
		.intclk, .rst_n, .line_in, .sample, .cfg(u_cfg.engine),
		.counts, .sample_count, .integrating, .done
	);

	frame_sender u_sender (
		.intclk, .rst_n, .counts, .sample_count, .done, .tx_busy,
		.tx_byte, .tx_load, .sending
	);

	uart_tx #(.BAUD_CYCLES(BAUD_CYCLES)) u_tx (
		.intclk, .rst_n, .tx_byte, .tx_load, .tx, .tx_busy
	);

	assign busy = integrating | sending;

endmodule

`default_nettype wire

//--- frame_sender.sv
/*
 * Snapshots the counts on done and streams one frame into the UART.
 * A byte is loaded only while tx_busy is low, one load per character.
 * sending drops once the stop bit of the last byte is out.
 */
`timescale 1ns/10ps
`default_nettype none

module frame_sender
	import corr_frame_pkg::*;
(
	input  wire                intclk,
	input  wire                rst_n,
	input  wire [FRAME_W-1:0]  counts,
	input  wire [SCNT_W-1:0]   sample_count,
	input  wire                done,
	input  wire                tx_busy,
	output logic [7:0]         tx_byte,
	output logic               tx_load,
	output logic               sending
);

	localparam int IDX_W = $clog2(FRAME_BYTES + 1);

	logic [FRAME_W-1:0] snap_counts;
	logic [SCNT_W-1:0]  snap_samples;
	logic [IDX_W-1:0]   idx;
	logic [7:0]         next_byte;
	logic               load_now;

	// byte mux over the frame layout
	always_comb begin
		int p;
		int off;
		p   = int'(idx) - HDR_BYTES;
		off = 0;
		if (idx == '0) begin
			next_byte = SYNC_BYTE;
		end else if (idx == IDX_W'(1)) begin
			next_byte = LAYOUT_BYTE;
		end else if (p < PAYLOAD_BYTES) begin
			// high byte of each word first
			off       = (p - p % WORD_BYTES + WORD_BYTES - 1 - p % WORD_BYTES) * 8;
			next_byte = snap_counts[off +: 8];
		end else begin
			off       = (SCNT_W / 8 - 1 - (p - PAYLOAD_BYTES)) * 8;
			next_byte = snap_samples[off +: 8];
		end
	end

	assign load_now = sending && !tx_busy && !tx_load && idx != IDX_W'(FRAME_BYTES);

	always_ff @(posedge intclk) begin
		if (done) begin
			snap_counts  <= counts;
			snap_samples <= sample_count;
		end
		if (load_now)
			tx_byte <= next_byte;
	end

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			sending <= 1'b0;
			tx_load <= 1'b0;
			idx     <= '0;
		end else begin
			tx_load <= load_now;
			if (done) begin
				sending <= 1'b1;
				idx     <= '0;
			end else if (load_now) begin
				idx <= idx + 1'b1;
			end else if (sending && idx == IDX_W'(FRAME_BYTES) && !tx_busy && !tx_load) begin
				sending <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- corr_engine.sv
/*
 * 1-bit correlation engine: ones, auto lags 1..NUM_LAGS, zero-lag cross.
 * Counters saturate at all ones and only move on sample strobes while integrating.
 * Counts are undefined after reset until the first start.
 */
`timescale 1ns/10ps
`default_nettype none

module corr_engine
	import corr_cfg_pkg::*;
	import corr_frame_pkg::*;
(
	input  wire                  intclk,
	input  wire                  rst_n,
	input  wire [NUM_INPUTS-1:0] line_in,
	input  wire                  sample,
	corr_cfg_if.engine           cfg,
	output logic [FRAME_W-1:0]   counts,
	output logic [SCNT_W-1:0]    sample_count,
	output logic                 integrating,
	output logic                 done
);

	logic [NUM_INPUTS-1:0] cond;
	logic [NUM_INPUTS-1:0] hist [NUM_LAGS];
	logic [COUNT_W-1:0]    cnt [FRAME_WORDS];
	logic [FRAME_WORDS-1:0] inc;
	logic [SCNT_W-1:0]     sample_next;
	logic [LEN_W:0]        len_q;
	logic                  fin;

	assign cond        = line_in ^ cfg.invert_mask;
	assign sample_next = sample_count + 1'b1;

	always_comb begin
		int k;
		inc = '0;
		for (int c = 0; c < NUM_INPUTS; c++) begin
			inc[ONES_BASE + c] = cfg.enable_mask[c] & cond[c];
			for (int l = 0; l < NUM_LAGS; l++)
				inc[AUTO_BASE + c * NUM_LAGS + l] = cfg.enable_mask[c] & ~(cond[c] ^ hist[l][c]);
		end
		// pairs (0,1) (0,2) ... in frame order
		k = CROSS_BASE;
		for (int a = 0; a < NUM_INPUTS; a++) begin
			for (int b = a + 1; b < NUM_INPUTS; b++) begin
				inc[k] = cfg.enable_mask[a] & cfg.enable_mask[b] & ~(cond[a] ^ cond[b]);
				k++;
			end
		end
	end

	always_ff @(posedge intclk) begin
		if (cfg.start) begin
			for (int w = 0; w < FRAME_WORDS; w++)
				cnt[w] <= '0;
			for (int l = 0; l < NUM_LAGS; l++)
				hist[l] <= '0;
			sample_count <= '0;
			len_q        <= cfg.int_len;
		end else if (integrating && sample) begin
			for (int w = 0; w < FRAME_WORDS; w++)
				if (inc[w] && cnt[w] != '1)
					cnt[w] <= cnt[w] + 1'b1;
			hist[0] <= cond;
			for (int l = 1; l < NUM_LAGS; l++)
				hist[l] <= hist[l-1];
			sample_count <= sample_next;
		end
	end

	// window control, done trails the falling edge of integrating
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			integrating <= 1'b0;
			fin         <= 1'b0;
			done        <= 1'b0;
		end else begin
			done <= fin;
			fin  <= 1'b0;
			if (cfg.start) begin
				integrating <= 1'b1;
			end else if (integrating && sample && sample_next == SCNT_W'(len_q)) begin
				integrating <= 1'b0;
				fin         <= 1'b1;
			end
		end
	end

	for (genvar w = 0; w < FRAME_WORDS; w++) begin : g_pack
		assign counts[w*COUNT_W +: COUNT_W] = cnt[w];
	end

endmodule

`default_nettype wire

//--- cmd_regs.sv
/*
 * Command decoder and configuration registers.
 * Mask and length bytes are always taken, a new length applies at the next start.
 * START is dropped while busy is high.
 */
`timescale 1ns/10ps
`default_nettype none

module cmd_regs
	import corr_cfg_pkg::*;
(
	input  wire        intclk,
	input  wire        rst_n,
	input  wire [7:0]  rx_byte,
	input  wire        rx_valid,
	input  wire        busy,
	corr_cfg_if.regs   cfg
);

	localparam logic [LEN_W:0] LEN_MAX = (LEN_W + 1)'(1 << LEN_W);

	cmd_word_u      cmd;
	logic [LEN_W:0] len_full;

	assign cmd = rx_byte;

	// zero selects the longest window
	assign len_full = (cmd.l.len == '0) ? LEN_MAX : {1'b0, cmd.l.len};

	// --------------------
	// register updates
	// --------------------
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			cfg.invert_mask <= '0;
			cfg.enable_mask <= '1;
			cfg.int_len     <= LEN_MAX;
			cfg.start       <= 1'b0;
		end else begin
			cfg.start <= 1'b0;
			if (rx_valid) begin
				case (cmd.m.op)
					OP_INVERT: cfg.invert_mask <= cmd.m.mask;
					OP_ENABLE: cfg.enable_mask <= cmd.m.mask;
					OP_LENGTH: cfg.int_len     <= len_full;
					OP_START:  cfg.start       <= ~busy;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- uart_tx.sv
/*
 * 8N1 transmitter, BAUD_CYCLES clocks per bit (at least 2).
 * tx_load is taken only while tx_busy is low.
 * tx_busy rises the cycle after the load and falls at the end of the stop bit.
 */
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
	parameter int BAUD_CYCLES = 8
) (
	input  wire       intclk,
	input  wire       rst_n,
	input  wire [7:0] tx_byte,
	input  wire       tx_load,
	output logic      tx,
	output logic      tx_busy
);

	localparam int CNT_W = $clog2(BAUD_CYCLES);

	logic [9:0]       shreg;
	logic [CNT_W-1:0] cnt;
	logic [3:0]       bit_idx;

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			shreg   <= '1;
			cnt     <= '0;
			bit_idx <= '0;
			tx_busy <= 1'b0;
		end else if (!tx_busy) begin
			if (tx_load) begin
				// stop, data, start
				shreg   <= {1'b1, tx_byte, 1'b0};
				cnt     <= '0;
				bit_idx <= '0;
				tx_busy <= 1'b1;
			end
		end else if (cnt == CNT_W'(BAUD_CYCLES - 1)) begin
			cnt     <= '0;
			shreg   <= {1'b1, shreg[9:1]};
			bit_idx <= bit_idx + 1'b1;
			if (bit_idx == 4'd9)
				tx_busy <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// idle line is high since ones shift in behind the frame
	assign tx = shreg[0];

endmodule

`default_nettype wire

//--- uart_rx.sv
/*
 * 8N1 receiver, BAUD_CYCLES clocks per bit (at least 2).
 * rx_byte is valid with rx_valid and holds until the next frame's data.
 * Frames with a low stop bit are dropped silently.
 */
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
	parameter int BAUD_CYCLES = 8
) (
	input  wire        intclk,
	input  wire        rst_n,
	input  wire        rx,
	output logic [7:0] rx_byte,
	output logic       rx_valid
);

	localparam int CNT_W = $clog2(BAUD_CYCLES);

	localparam logic [1:0] S_IDLE  = 2'd0;
	localparam logic [1:0] S_START = 2'd1;
	localparam logic [1:0] S_DATA  = 2'd2;
	localparam logic [1:0] S_STOP  = 2'd3;

	logic [1:0]       rx_sync;
	logic [1:0]       state;
	logic [CNT_W-1:0] cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shreg;
	logic             bit_tick;

	assign bit_tick = (cnt == CNT_W'(BAUD_CYCLES - 1));

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			rx_sync  <= 2'b11;
			state    <= S_IDLE;
			cnt      <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync  <= {rx_sync[0], rx};
			rx_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					cnt <= '0;
					if (!rx_sync[1])
						state <= S_START;
				end
				// recheck the start bit at its middle
				S_START: begin
					if (cnt == CNT_W'(BAUD_CYCLES / 2 - 1)) begin
						cnt     <= '0;
						bit_idx <= '0;
						state   <= rx_sync[1] ? S_IDLE : S_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (bit_tick) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= S_STOP;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					if (bit_tick) begin
						rx_valid <= rx_sync[1];
						state    <= S_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// lsb first
	always_ff @(posedge intclk) begin
		if (state == S_DATA && bit_tick)
			shreg <= {rx_sync[1], shreg[7:1]};
	end

	assign rx_byte = shreg;

endmodule

`default_nettype wire

//--- corr_cfg_if.sv
/*
 * Configuration path from the command registers to the engine.
 * int_len is already expanded, so it can hold 1 << LEN_W.
 * start is a single-cycle pulse.
 */
`timescale 1ns/10ps
`default_nettype none

interface corr_cfg_if
	import corr_cfg_pkg::*;
();

	logic [NUM_INPUTS-1:0] invert_mask;
	logic [NUM_INPUTS-1:0] enable_mask;
	logic [LEN_W:0]        int_len;
	logic                  start;

	modport regs (
		output invert_mask, enable_mask, int_len, start
	);

	modport engine (
		input invert_mask, enable_mask, int_len, start
	);

endinterface

`default_nettype wire

//--- corr_frame_pkg.sv
/*
 * Output frame layout. Words are COUNT_W wide and go out high byte first.
 * Order is sync, layout, ones, auto (lag-minor), cross, sample count.
 */
`default_nettype none

package corr_frame_pkg;
	import corr_cfg_pkg::*;

	localparam logic [7:0] SYNC_BYTE   = 8'hC5;
	localparam logic [7:0] LAYOUT_BYTE = {4'(NUM_INPUTS - 1), 4'(NUM_LAGS)};

	// word offsets inside the count vector
	localparam int ONES_BASE   = 0;
	localparam int AUTO_BASE   = ONES_BASE + NUM_INPUTS;
	localparam int CROSS_BASE  = AUTO_BASE + NUM_INPUTS * NUM_LAGS;
	localparam int FRAME_WORDS = CROSS_BASE + NUM_BASELINES;
	localparam int FRAME_W     = FRAME_WORDS * COUNT_W;

	localparam int WORD_BYTES    = COUNT_W / 8;
	localparam int SCNT_W        = 16;
	localparam int HDR_BYTES     = 2;
	localparam int PAYLOAD_BYTES = FRAME_WORDS * WORD_BYTES;
	localparam int FRAME_BYTES   = HDR_BYTES + PAYLOAD_BYTES + SCNT_W / 8;

endpackage

`default_nettype wire

//--- corr_cfg_pkg.sv
/*
 * Correlator geometry and command byte encoding.
 * The opcode sits in the top two bits of every command byte.
 * A length field of zero stands for the longest window, 1 << LEN_W samples.
 */
`default_nettype none

package corr_cfg_pkg;

	localparam int NUM_INPUTS    = 4;
	localparam int NUM_LAGS      = 2;
	localparam int NUM_BASELINES = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int COUNT_W       = 16;
	localparam int LEN_W         = 6;

	typedef enum logic [1:0] {
		OP_INVERT = 2'd0,
		OP_ENABLE = 2'd1,
		OP_LENGTH = 2'd2,
		OP_START  = 2'd3
	} cmd_op_e;

	// mask view, one bit per channel
	typedef struct packed {
		cmd_op_e               op;
		logic [1:0]            unused;
		logic [NUM_INPUTS-1:0] mask;
	} cmd_mask_t;

	// length view
	typedef struct packed {
		cmd_op_e          op;
		logic [LEN_W-1:0] len;
	} cmd_len_t;

	typedef union packed {
		cmd_mask_t m;
		cmd_len_t  l;
	} cmd_word_u;

endpackage

`default_nettype wire
